/* include/uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// register window, word addresses
`define UART_ADDR_W      3
`define UART_DIV         3'd0
`define UART_DATA        3'd1
`define UART_WRITE_WAIT  3'd2
`define UART_READ_VALID  3'd3
`define UART_SOFT_RESET  3'd4
`define UART_RXEN        3'd5

// divider value after reset
`define UART_DIV_RESET   1

// bus word and divider width
`define UART_DIV_W       32

// bit-period counters, divider must stay below 2**UART_CNT_W
`define UART_CNT_W       16

// serial character
`define UART_BYTE_W      8

`endif

/* hw/uart_pkg.sv */
`default_nettype none

`include "uart_params.svh"

package uart_pkg;

   // byte view of a cpu write word
   typedef struct packed {
      logic [`UART_DIV_W-`UART_BYTE_W-1:0] pad;
      logic [`UART_BYTE_W-1:0]             data;
   } uart_wbyte_t;

   // one bus word, decoded as a divider or as a byte
   typedef union packed {
      logic [`UART_DIV_W-1:0] divider;
      uart_wbyte_t            fields;
   } uart_wdata_u;

   // receiver phases
   typedef enum logic [1:0] {
      RX_IDLE  = 2'd0,
      RX_START = 2'd1,
      RX_DATA  = 2'd2,
      RX_STOP  = 2'd3
   } rx_state_e;

endpackage

`default_nettype wire

/* hw/uart_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

interface uart_ctrl_if;

   // register side to datapaths
   logic [`UART_DIV_W-1:0]  divider;
   logic                    tx_load;
   logic [`UART_BYTE_W-1:0] tx_byte;
   logic                    rx_read;

   // datapaths back to registers
   logic                    tx_busy;
   logic [`UART_BYTE_W-1:0] rx_byte;
   logic                    rx_valid;
   logic                    rx_hold;

   modport regs (
      output divider, tx_load, tx_byte, rx_read,
      input  tx_busy, rx_byte, rx_valid, rx_hold
   );

   modport tx (input tx_load, tx_byte, output tx_busy);

   modport rx (input rx_read, output rx_byte, rx_valid, rx_hold);

endinterface

`default_nettype wire

/* hw/uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_regs (
   input  wire                         clk,
   input  wire                         rst_int,
   input  wire                         valid,
   input  wire [`UART_ADDR_W-1:0]      address,
   input  wire uart_pkg::uart_wdata_u  wdata,
   input  wire                         wstrb,
   input  wire                         cts,
   output logic [`UART_DIV_W-1:0]      rdata,
   output logic                        ready,
   output logic                        rts,
   output logic                        core_rst,
   uart_ctrl_if.regs                   ctrl
);

   logic       div_we;
   logic       soft_we;
   logic       rxen_we;
   logic       soft_q;
   logic       rx_en;
   logic [1:0] cts_sync;

   ////////////////////////////////////////////////////////////////////////////
   // address decode
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      div_we       = 1'b0;
      ctrl.tx_load = 1'b0;
      soft_we      = 1'b0;
      rxen_we      = 1'b0;
      if (valid && wstrb) begin
         case (address)
            `UART_DIV:        div_we       = 1'b1;
            `UART_DATA:       ctrl.tx_load = 1'b1;
            `UART_SOFT_RESET: soft_we      = 1'b1;
            `UART_RXEN:       rxen_we      = 1'b1;
            default:          ;
         endcase
      end
   end

   assign ctrl.tx_byte = wdata.fields.data;

   // a data read frees the receive buffer
   assign ctrl.rx_read = valid && !wstrb && (address == `UART_DATA);

   ////////////////////////////////////////////////////////////////////////////
   // bus ready and reset
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         ready    <= 1'b0;
         soft_q   <= 1'b0;
         cts_sync <= 2'b11;
      end else begin
         ready    <= valid;
         soft_q   <= soft_we && wdata.fields.data[0];
         cts_sync <= {cts_sync[0], cts};
      end
   end

   assign core_rst = rst_int | soft_q;

   // divider and receive enable
   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         ctrl.divider <= `UART_DIV_W'(`UART_DIV_RESET);
         rx_en        <= 1'b0;
      end else begin
         if (div_we) begin
            ctrl.divider <= wdata.divider;
         end
         if (rxen_we) begin
            rx_en <= wdata.fields.data[0];
         end
      end
   end

   assign rts = rx_en & ~ctrl.rx_hold;

   // read mux
   always_comb begin
      case (address)
         `UART_DIV:        rdata = ctrl.divider;
         `UART_DATA:       rdata = {24'd0, ctrl.rx_byte};
         `UART_WRITE_WAIT: rdata = {31'd0, ctrl.tx_busy | ~cts_sync[1]};
         `UART_READ_VALID: rdata = {31'd0, ctrl.rx_valid};
         `UART_RXEN:       rdata = {31'd0, rx_en};
         default:          rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/uart_baud_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_baud_timer (
   input  wire                    clk,
   input  wire                    core_rst,
   input  wire                    restart,
   input  wire [`UART_CNT_W-1:0]  divider,
   output logic                   half_tick,
   output logic                   full_tick
);

   // zero means stopped, otherwise 1 .. divider
   logic [`UART_CNT_W-1:0] cnt;
   logic                   active;

   assign active = (cnt != '0);

   // end of a bit period
   assign full_tick = active && (cnt == divider);

   // middle of a bit period, rounded up for odd dividers
   assign half_tick = active && ({cnt, 1'b0} >= {1'b0, divider});

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         cnt <= '0;
      end else if (restart || full_tick) begin
         cnt <= `UART_CNT_W'(1);
      end else if (active) begin
         cnt <= cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hw/uart_rx_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fsm (
   input  wire                    clk,
   input  wire                    core_rst,
   input  wire                    rxd,
   input  wire                    half_tick,
   input  wire                    full_tick,
   output logic                   restart,
   output logic                   shift,
   output logic                   done,
   output uart_pkg::rx_state_e    state
);

   import uart_pkg::*;

   logic [2:0] bit_cnt;

   // timer held at the start of a period while idle,
   // then realigned once at the middle of the start bit
   assign restart = (state == RX_IDLE) || ((state == RX_START) && half_tick);

   assign shift = (state == RX_DATA) && full_tick;
   assign done  = (state == RX_STOP) && full_tick;

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         state   <= RX_IDLE;
         bit_cnt <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               // falling edge of the start bit
               if (!rxd) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (half_tick) begin
                  state   <= RX_DATA;
                  bit_cnt <= '0;
               end
            end
            RX_DATA: begin
               if (full_tick) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) begin
                     state <= RX_STOP;
                  end
               end
            end
            RX_STOP: begin
               // back to idle in the middle of the stop bit
               if (full_tick) begin
                  state <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/uart_rx_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_rx_buffer (
   input  wire        clk,
   input  wire        core_rst,
   input  wire        rxd,
   input  wire        shift,
   input  wire        done,
   input  wire        start_seen,
   uart_ctrl_if.rx    ctrl
);

   logic [`UART_BYTE_W-1:0] shreg;

   // lsb arrives first, so shift in from the top
   always_ff @(posedge clk) begin
      if (shift) begin
         shreg <= {rxd, shreg[`UART_BYTE_W-1:1]};
      end
      if (done) begin
         ctrl.rx_byte <= shreg;
      end
   end

   // new events win over a read in the same cycle
   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         ctrl.rx_valid <= 1'b0;
         ctrl.rx_hold  <= 1'b0;
      end else begin
         if (ctrl.rx_read) begin
            ctrl.rx_valid <= 1'b0;
            ctrl.rx_hold  <= 1'b0;
         end
         if (done) begin
            ctrl.rx_valid <= 1'b1;
         end
         if (start_seen) begin
            ctrl.rx_hold <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/uart_tx_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_tx_shifter (
   input  wire        clk,
   input  wire        core_rst,
   input  wire        full_tick,
   output logic       txd,
   uart_ctrl_if.tx    ctrl
);

   // stop, data and start bits, start bit at position 0
   logic [`UART_BYTE_W+1:0] frame;
   logic [3:0]              bit_cnt;

   assign ctrl.tx_busy = (bit_cnt != 4'd0);

   ////////////////////////////////////////////////////////////////////////////
   // frame shifter
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         frame   <= '1;
         bit_cnt <= 4'd0;
      end else if (ctrl.tx_load) begin
         // a write during a frame starts over
         frame   <= {1'b1, ctrl.tx_byte, 1'b0};
         bit_cnt <= 4'd10;
      end else if (full_tick && ctrl.tx_busy) begin
         // fill with ones so the line rests high
         frame   <= {1'b1, frame[`UART_BYTE_W+1:1]};
         bit_cnt <= bit_cnt - 1'b1;
      end
   end

   assign txd = frame[0];

endmodule

`default_nettype wire

/* hw/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_top (
   input  wire                      clk,
   input  wire                      rst_int,
   input  wire                      valid,
   input  wire [`UART_ADDR_W-1:0]   address,
   input  wire [`UART_DIV_W-1:0]    wdata,
   input  wire                      wstrb,
   output wire [`UART_DIV_W-1:0]    rdata,
   output wire                      ready,
   output wire                      txd,
   input  wire                      rxd,
   input  wire                      cts,
   output wire                      rts
);

   import uart_pkg::*;

   wire       core_rst;
   wire       tx_full_tick;
   wire       rx_half_tick;
   wire       rx_full_tick;
   wire       rx_restart;
   wire       rx_shift;
   wire       rx_done;
   rx_state_e rx_state;

   // leaving idle on a low line
   wire       start_seen = (rx_state == RX_IDLE) && !rxd;

   uart_ctrl_if ctrl_if ();

   uart_regs uart_regs_i (
      .clk      (clk),
      .rst_int  (rst_int),
      .valid    (valid),
      .address  (address),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .cts      (cts),
      .rdata    (rdata),
      .ready    (ready),
      .rts      (rts),
      .core_rst (core_rst),
      .ctrl     (ctrl_if)
   );

   ////////////////////////////////////////////////////////////////////////////
   // transmit path
   ////////////////////////////////////////////////////////////////////////////

   uart_baud_timer tx_timer_i (
      .clk       (clk),
      .core_rst  (core_rst),
      .restart   (ctrl_if.tx_load),
      .divider   (ctrl_if.divider[`UART_CNT_W-1:0]),
      .half_tick (),
      .full_tick (tx_full_tick)
   );

   uart_tx_shifter uart_tx_shifter_i (
      .clk       (clk),
      .core_rst  (core_rst),
      .full_tick (tx_full_tick),
      .txd       (txd),
      .ctrl      (ctrl_if)
   );

   ////////////////////////////////////////////////////////////////////////////
   // receive path
   ////////////////////////////////////////////////////////////////////////////

   uart_baud_timer rx_timer_i (
      .clk       (clk),
      .core_rst  (core_rst),
      .restart   (rx_restart),
      .divider   (ctrl_if.divider[`UART_CNT_W-1:0]),
      .half_tick (rx_half_tick),
      .full_tick (rx_full_tick)
   );

   uart_rx_fsm uart_rx_fsm_i (
      .clk       (clk),
      .core_rst  (core_rst),
      .rxd       (rxd),
      .half_tick (rx_half_tick),
      .full_tick (rx_full_tick),
      .restart   (rx_restart),
      .shift     (rx_shift),
      .done      (rx_done),
      .state     (rx_state)
   );

   uart_rx_buffer uart_rx_buffer_i (
      .clk        (clk),
      .core_rst   (core_rst),
      .rxd        (rxd),
      .shift      (rx_shift),
      .done       (rx_done),
      .start_seen (start_seen),
      .ctrl       (ctrl_if)
   );

endmodule

`default_nettype wire

/* tests/uart_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_checker (
   input wire                       clk,
   input wire                       rst_int,
   input wire                       valid,
   input wire                       ready,
   input wire                       txd,
   input wire                       tx_busy,
   input wire uart_pkg::rx_state_e  rx_state
);

   import uart_pkg::*;

   // failed assertion count
   int fail_cnt = 0;

   // bus ready is valid one cycle later
   ready_follows_valid: assert property (@(posedge clk) disable iff (rst_int)
      ready == $past(valid))
      else begin
         $error("ready does not follow valid by one cycle");
         fail_cnt++;
      end

   // line rests high between frames
   txd_idle_high: assert property (@(posedge clk) disable iff (rst_int)
      !tx_busy |-> txd)
      else begin
         $error("txd low while the transmitter is idle");
         fail_cnt++;
      end

   rx_state_legal: assert property (@(posedge clk) disable iff (rst_int)
      rx_state inside {RX_IDLE, RX_START, RX_DATA, RX_STOP})
      else begin
         $error("receive state outside its enumeration");
         fail_cnt++;
      end

endmodule

bind uart_top uart_checker uart_checker_i (
   .clk      (clk),
   .rst_int  (rst_int),
   .valid    (valid),
   .ready    (ready),
   .txd      (txd),
   .tx_busy  (ctrl_if.tx_busy),
   .rx_state (rx_state)
);

`default_nettype wire

/* tests/uart_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_monitor (
   input  wire                    clk,
   input  wire                    rst_int,
   input  wire                    valid,
   input  wire [`UART_ADDR_W-1:0] address,
   input  wire [`UART_DIV_W-1:0]  wdata,
   input  wire                    wstrb,
   input  wire [`UART_DIV_W-1:0]  rdata,
   input  wire                    ready,
   input  wire                    txd,
   input  wire                    rxd,
   input  wire                    cts,
   input  wire                    rts,
   input  wire                    rx_sent,
   input  wire [7:0]              rx_sent_byte,
   output int                     checks,
   output int                     errors
);

   // shadow of the register window
   logic [31:0] div_m;
   logic        rx_en_m;
   logic        hold_m;
   logic        pend_m;
   logic [7:0]  rx_byte_m;
   logic [7:0]  tx_byte_m;
   logic [1:0]  cts_m;
   logic        valid_q;
   logic [9:0]  frame_m;
   int          tx_age;
   int          tx_div;
   int          rx_cnt;

   // start bit first, stop bit last
   function automatic logic [9:0] frame_bits(input logic [7:0] b);
      return {1'b1, b, 1'b0};
   endfunction

   function automatic logic [31:0] read_value(input logic [2:0] a);
      case (a)
         `UART_DIV:        return div_m;
         `UART_DATA:       return {24'd0, rx_byte_m};
         `UART_WRITE_WAIT: return {31'd0, (tx_age != 0) | ~cts_m[1]};
         `UART_READ_VALID: return {31'd0, pend_m};
         `UART_RXEN:       return {31'd0, rx_en_m};
         default:          return 32'd0;
      endcase
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // compare first, then advance the model
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (rst_int) begin
         div_m     = `UART_DIV_RESET;
         rx_en_m   = 1'b0;
         hold_m    = 1'b0;
         pend_m    = 1'b0;
         rx_byte_m = 8'd0;
         tx_byte_m = 8'd0;
         cts_m     = 2'b11;
         valid_q   = 1'b0;
         tx_age    = 0;
         tx_div    = 1;
         rx_cnt    = 0;
         checks    = 0;
         errors    = 0;
      end else begin
         compare_value("ready", ready, valid_q);
         compare_value("rts", rts, rx_en_m & ~hold_m);
         if (tx_age != 0) begin
            // mid-bit sample
            if ((tx_age % tx_div) == tx_div / 2) begin
               frame_m = frame_bits(tx_byte_m);
               compare_value("txd", txd, frame_m[tx_age / tx_div]);
            end
         end else begin
            compare_value("txd", txd, 1'b1);
         end
         if (valid && !wstrb) begin
            compare_value($sformatf("rdata[%0d]", address), rdata, read_value(address));
         end

         valid_q = valid;
         cts_m   = {cts_m[0], cts};
         if (tx_age == 10 * tx_div) tx_age = 0;
         else if (tx_age != 0) tx_age++;
         if (rx_sent) begin
            pend_m    = 1'b1;
            rx_byte_m = rx_sent_byte;
         end
         if (valid && !wstrb && address == `UART_DATA) begin
            pend_m = 1'b0;
            hold_m = 1'b0;
         end
         // start bit seen while the receiver is idle
         if (rx_cnt != 0) begin
            rx_cnt--;
         end else if (!rxd) begin
            rx_cnt = 10 * div_m;
            hold_m = 1'b1;
         end
         if (valid && wstrb) begin
            case (address)
               `UART_DIV: div_m = wdata;
               `UART_DATA: begin
                  tx_byte_m = wdata[7:0];
                  tx_div    = div_m;
                  tx_age    = 1;
               end
               `UART_RXEN: rx_en_m = wdata[0];
               `UART_SOFT_RESET: begin
                  if (wdata[0]) begin
                     div_m   = `UART_DIV_RESET;
                     rx_en_m = 1'b0;
                     hold_m  = 1'b0;
                     pend_m  = 1'b0;
                     tx_age  = 0;
                     rx_cnt  = 0;
                  end
               end
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* tests/uart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_tb;

   logic        clk = 1'b0;
   logic        rst_int;
   logic        valid;
   logic [2:0]  address;
   logic [31:0] wdata;
   logic        wstrb;
   logic        rxd;
   logic        cts;
   logic        rx_sent;
   logic [7:0]  rx_sent_byte;
   wire  [31:0] rdata;
   wire         ready;
   wire         txd;
   wire         rts;
   int          checks;
   int          errors;
   int          assert_fails;
   int          cycles;
   int          limit;
   int          dtx;
   int          drx;
   logic [31:0] q;
   logic [7:0]  b;

   always #20 clk = ~clk;

   uart_top uart_top_i (
      .clk (clk), .rst_int (rst_int), .valid (valid), .address (address),
      .wdata (wdata), .wstrb (wstrb), .rdata (rdata), .ready (ready),
      .txd (txd), .rxd (rxd), .cts (cts), .rts (rts)
   );

   uart_monitor checks_i (
      .clk (clk), .rst_int (rst_int), .valid (valid), .address (address),
      .wdata (wdata), .wstrb (wstrb), .rdata (rdata), .ready (ready),
      .txd (txd), .rxd (rxd), .cts (cts), .rts (rts), .rx_sent (rx_sent),
      .rx_sent_byte (rx_sent_byte), .checks (checks), .errors (errors)
   );

   // one valid cycle and read data taken at the sampling edge
   task automatic bus_access(input logic [2:0] a, input logic we, input logic [31:0] d,
                             output logic [31:0] r);
      @(posedge clk);
      valid   <= 1'b1;
      wstrb   <= we;
      address <= a;
      wdata   <= d;
      @(posedge clk);
      r = rdata;
      valid <= 1'b0;
      wstrb <= 1'b0;
   endtask

   task automatic bus_write(input logic [2:0] a, input logic [31:0] d);
      logic [31:0] unused;
      bus_access(a, 1'b1, d, unused);
   endtask

   task automatic bus_read(input logic [2:0] a, output logic [31:0] r);
      bus_access(a, 1'b0, 32'd0, r);
   endtask

   task automatic wait_tx_idle();
      logic [31:0] r;
      do bus_read(`UART_WRITE_WAIT, r); while (r[0]);
   endtask

   task automatic send_serial(input logic [7:0] data, input int d);
      logic [9:0] bits;
      bits = {1'b1, data, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         rxd <= bits[i];
         repeat (d - 1) @(posedge clk);
      end
      @(posedge clk);
      rx_sent      <= 1'b1;
      rx_sent_byte <= data;
      @(posedge clk);
      rx_sent <= 1'b0;
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("run stopped, no progress after %0d cycles", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial begin
      void'($urandom(93));
      rst_int      = 1'b1;
      valid        = 1'b0;
      wstrb        = 1'b0;
      address      = 3'd0;
      wdata        = 32'd0;
      rxd          = 1'b1;
      cts          = 1'b1;
      rx_sent      = 1'b0;
      rx_sent_byte = 8'd0;
      cycles       = 0;
      dtx          = 4 + $urandom % 17;
      drx          = 4 + $urandom % 17;
      // three frames out, four frames in, one frame at divider 8
      limit        = 12 * dtx * 3 + 12 * drx * 4 + 12 * 8 + 200 * 6;
      repeat (4) @(posedge clk);
      rst_int <= 1'b0;

      // reset values
      bus_read(`UART_DIV, q);
      bus_read(`UART_READ_VALID, q);

      // divider read back
      repeat (4) begin
         bus_write(`UART_DIV, 4 + $urandom % 17);
         bus_read(`UART_DIV, q);
      end

      // transmit frames
      bus_write(`UART_DIV, dtx);
      repeat (3) begin
         b = $urandom;
         bus_write(`UART_DATA, {24'd0, b});
         bus_read(`UART_WRITE_WAIT, q);
         wait_tx_idle();
      end

      // receive frames
      bus_write(`UART_DIV, drx);
      bus_write(`UART_RXEN, 32'd1);
      repeat (3) begin
         send_serial($urandom, drx);
         bus_read(`UART_READ_VALID, q);
         bus_read(`UART_DATA, q);
         bus_read(`UART_READ_VALID, q);
      end

      // flow control
      @(posedge clk);
      cts <= 1'b0;
      repeat (3) @(posedge clk);
      bus_read(`UART_WRITE_WAIT, q);
      cts <= 1'b1;
      repeat (3) @(posedge clk);
      bus_read(`UART_WRITE_WAIT, q);

      // soft reset with a byte waiting and a frame in progress
      send_serial($urandom, drx);
      bus_read(`UART_READ_VALID, q);
      bus_write(`UART_DIV, 8);
      bus_write(`UART_DATA, 32'h00);
      repeat (12) @(posedge clk);
      bus_write(`UART_SOFT_RESET, 32'd1);
      bus_read(`UART_DIV, q);
      bus_read(`UART_READ_VALID, q);
      bus_read(`UART_RXEN, q);
      repeat (4) @(posedge clk);

      assert_fails = uart_top_i.uart_checker_i.fail_cnt;
      $display("checks %0d errors %0d assertion failures %0d", checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
hw/uart_pkg.sv
hw/uart_ctrl_if.sv
hw/uart_regs.sv
hw/uart_baud_timer.sv
hw/uart_rx_fsm.sv
hw/uart_rx_buffer.sv
hw/uart_tx_shifter.sv
hw/uart_top.sv
tests/uart_checker.sv
tests/uart_monitor.sv
tests/uart_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= uart_tb
RTL_TOP   ?= uart_top
FILELIST  ?= filelist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD) -o V$(TOP)

sim: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
